// File: rtl/armCtrlPkg.sv
package armCtrlPkg;

  // Instruction word, read as data processing or as load/store
  typedef union packed {
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  instrClass;
      logic        imm;         // Operand 2 is an immediate
      logic [3:0]  opcode;
      logic        sBit;        // Set flags
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand;
    } dp;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  instrClass;
      logic        regForm;     // Register offset for word access
      logic        p;
      logic        u;           // Add offset when set
      logic        b;           // Byte for word class, immediate form for halfword
      logic        w;
      logic        l;           // Load when set
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] offset;
    } mem;
  } instrT;

  // Ordered N, Z, C, V from the top bit down
  typedef logic [3:0] flagsT;

  // ALU operation codes
  typedef logic [2:0] aluOpT;
  localparam aluOpT AluAnd = 3'd0;
  localparam aluOpT AluEor = 3'd1;
  localparam aluOpT AluAdd = 3'd2;
  localparam aluOpT AluOrr = 3'd3;
  localparam aluOpT AluMov = 3'd4;
  localparam aluOpT AluBic = 3'd5;
  localparam aluOpT AluMvn = 3'd6;

  // Data processing opcodes, also used as ALU control
  localparam logic [3:0] OpAnd = 4'b0000;
  localparam logic [3:0] OpEor = 4'b0001;
  localparam logic [3:0] OpSub = 4'b0010;
  localparam logic [3:0] OpRsb = 4'b0011;
  localparam logic [3:0] OpAdd = 4'b0100;
  localparam logic [3:0] OpAdc = 4'b0101;
  localparam logic [3:0] OpSbc = 4'b0110;
  localparam logic [3:0] OpRsc = 4'b0111;
  localparam logic [3:0] OpTst = 4'b1000;
  localparam logic [3:0] OpTeq = 4'b1001;
  localparam logic [3:0] OpCmp = 4'b1010;
  localparam logic [3:0] OpCmn = 4'b1011;
  localparam logic [3:0] OpOrr = 4'b1100;
  localparam logic [3:0] OpMov = 4'b1101;
  localparam logic [3:0] OpBic = 4'b1110;
  localparam logic [3:0] OpMvn = 4'b1111;

  // Condition field codes
  localparam logic [3:0] CondEq = 4'b0000;
  localparam logic [3:0] CondNe = 4'b0001;
  localparam logic [3:0] CondCs = 4'b0010;
  localparam logic [3:0] CondCc = 4'b0011;
  localparam logic [3:0] CondMi = 4'b0100;
  localparam logic [3:0] CondPl = 4'b0101;
  localparam logic [3:0] CondVs = 4'b0110;
  localparam logic [3:0] CondVc = 4'b0111;
  localparam logic [3:0] CondHi = 4'b1000;
  localparam logic [3:0] CondLs = 4'b1001;
  localparam logic [3:0] CondGe = 4'b1010;
  localparam logic [3:0] CondLt = 4'b1011;
  localparam logic [3:0] CondGt = 4'b1100;
  localparam logic [3:0] CondLe = 4'b1101;
  localparam logic [3:0] CondAl = 4'b1110;

endpackage

// File: rtl/execCtrlIf.sv
`timescale 1ns/10ps

// Registered Execute-stage controls
interface execCtrlIf;
  logic       aluOp;       // Data processing opcode in aluControl
  logic [3:0] aluControl;
  logic       aluSrc;
  logic [1:0] flagWrite;   // NZ on bit 1, CV on bit 0
  logic       branch;
  logic       memWrite;
  logic       regWrite;
  logic       memtoReg;
  logic       pcSrc;
  logic [3:0] cond;
  logic       halfword;
  logic       storeByte;

  modport decode (
    output aluOp, aluControl, aluSrc, flagWrite, branch, memWrite,
           regWrite, memtoReg, pcSrc, cond, halfword, storeByte
  );

  modport execute (
    input aluOp, aluControl, aluSrc, flagWrite, branch, memWrite,
          regWrite, memtoReg, pcSrc, cond, halfword, storeByte
  );

endinterface

// File: rtl/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder import armCtrlPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  instrT             InstrD,
  input  logic              StallE,
  input  logic              FlushE,
  output logic [1:0]        RegSrcD,
  output logic [1:0]        ImmSrcD,
  output logic              pcSrcD,
  execCtrlIf.decode         ctrl
);

  logic [9:0]  controlsD;
  logic        aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, aluOpD;
  logic        halfwordD, storeByteD;
  logic [3:0]  aluControlD;
  logic [1:0]  flagWriteD;
  logic [18:0] execD, execQ;

  // Control word for a load or store
  function automatic logic [9:0] memControls(input logic isLoad, input logic immForm);
    return {isLoad ? 2'b00 : 2'b10, 2'b01, immForm, isLoad, isLoad, ~isLoad, 2'b00};
  endfunction

  // ============================
  // Decode
  // ============================

  // {RegSrc, ImmSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp}
  always_comb begin
    halfwordD  = 1'b0;
    storeByteD = 1'b0;
    case (InstrD.dp.instrClass)
      2'b00: begin
        if (!InstrD.dp.imm && InstrD.dp.operand[7] && InstrD.dp.operand[4]) begin
          // Halfword transfer, bit 22 picks the immediate form
          halfwordD = 1'b1;
          controlsD = memControls(InstrD.mem.l, InstrD.mem.b);
        end else if (InstrD.dp.imm) begin
          controlsD = 10'b00_00_1_0_1_0_0_1;  // Data processing immediate
        end else begin
          controlsD = 10'b00_00_0_0_1_0_0_1;  // Data processing register
        end
      end
      2'b01: begin
        storeByteD = InstrD.mem.b & ~InstrD.mem.l;
        controlsD  = memControls(InstrD.mem.l, ~InstrD.mem.regForm);
      end
      2'b10:   controlsD = 10'b01_10_1_0_0_0_1_0;  // Branch
      default: controlsD = '0;                    // Unused class acts as a no-op
    endcase
  end

  assign {RegSrcD, ImmSrcD, aluSrcD, memtoRegD,
          regWriteD, memWriteD, branchD, aluOpD} = controlsD;

  always_comb begin
    if (aluOpD) begin
      aluControlD = InstrD.dp.opcode;
      flagWriteD  = {2{InstrD.dp.sBit}};
    end else if (InstrD.dp.instrClass == 2'b01 || halfwordD) begin
      aluControlD = InstrD.mem.u ? OpAdd : OpSub;  // Base plus or minus offset
      flagWriteD  = 2'b00;
    end else begin
      aluControlD = OpAdd;  // Branch target
      flagWriteD  = 2'b00;
    end
  end

  // Write to R15 redirects fetch
  assign pcSrcD = (InstrD.dp.rd == 4'hf && regWriteD) || branchD;

  // ============================
  // Decode to Execute register
  // ============================
  assign execD = {aluOpD, aluControlD, aluSrcD, flagWriteD, branchD, memWriteD,
                  regWriteD, memtoRegD, pcSrcD, InstrD.dp.cond, halfwordD, storeByteD};

  always_ff @(posedge clk) begin
    if (reset) begin
      execQ <= '0;
    end else if (!StallE) begin
      if (FlushE)
        execQ <= '0;  // Bubble
      else
        execQ <= execD;
    end
  end

  assign {ctrl.aluOp, ctrl.aluControl, ctrl.aluSrc, ctrl.flagWrite, ctrl.branch,
          ctrl.memWrite, ctrl.regWrite, ctrl.memtoReg, ctrl.pcSrc, ctrl.cond,
          ctrl.halfword, ctrl.storeByte} = execQ;

endmodule

// File: rtl/aluDecoder.sv
`timescale 1ns/10ps

module aluDecoder import armCtrlPkg::*; (
  execCtrlIf.execute ctrl,
  output aluOpT      ALUOperationE,
  output logic       InvertBE,
  output logic       ReverseInputsE,
  output logic       CVUpdateE,
  output logic       doNotWriteReg
);

  always_comb begin
    ALUOperationE  = AluAdd;
    InvertBE       = 1'b0;
    ReverseInputsE = 1'b0;
    CVUpdateE      = 1'b0;
    doNotWriteReg  = 1'b0;

    if (ctrl.aluOp) begin
      case (ctrl.aluControl)
        OpAnd, OpTst: ALUOperationE = AluAnd;
        OpEor, OpTeq: ALUOperationE = AluEor;
        OpOrr:        ALUOperationE = AluOrr;
        OpMov:        ALUOperationE = AluMov;
        OpBic:        ALUOperationE = AluBic;
        OpMvn:        ALUOperationE = AluMvn;
        OpSub, OpRsb, OpAdd, OpAdc,
        OpSbc, OpRsc, OpCmp, OpCmn: begin
          ALUOperationE = AluAdd;  // Subtracts reuse the adder
          CVUpdateE     = 1'b1;
        end
      endcase

      // Subtraction as A plus inverted B
      InvertBE       = ctrl.aluControl inside {OpSub, OpSbc, OpRsb, OpRsc, OpCmp};
      ReverseInputsE = ctrl.aluControl inside {OpRsb, OpRsc};

      // TST, TEQ, CMP and CMN only set flags
      doNotWriteReg  = (ctrl.aluControl[3:2] == 2'b10);
    end else begin
      InvertBE = (ctrl.aluControl == OpSub);  // Down offset on a load or store
    end
  end

endmodule

// File: rtl/condUnit.sv
`timescale 1ns/10ps

module condUnit import armCtrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       StallE,
  input  flagsT      FlagsE,
  execCtrlIf.execute ctrl,
  output logic       condEx,
  output flagsT      PreviousFlagsE
);

  flagsT flagsQ, flagsNext;
  logic  n, z, c, v;

  assign {n, z, c, v} = flagsQ;

  // Condition check against the stored flags
  always_comb begin
    case (ctrl.cond)
      CondEq:  condEx = z;
      CondNe:  condEx = ~z;
      CondCs:  condEx = c;
      CondCc:  condEx = ~c;
      CondMi:  condEx = n;
      CondPl:  condEx = ~n;
      CondVs:  condEx = v;
      CondVc:  condEx = ~v;
      CondHi:  condEx = c & ~z;
      CondLs:  condEx = ~c | z;
      CondGe:  condEx = (n == v);
      CondLt:  condEx = (n != v);
      CondGt:  condEx = ~z & (n == v);
      CondLe:  condEx = z | (n != v);
      CondAl:  condEx = 1'b1;
      default: condEx = 1'b0;  // 1111 never executes
    endcase
  end

  // NZ and CV pairs update separately
  always_comb begin
    flagsNext = flagsQ;
    if (condEx && ctrl.flagWrite[1])
      flagsNext[3:2] = FlagsE[3:2];
    if (condEx && ctrl.flagWrite[0])
      flagsNext[1:0] = FlagsE[1:0];
  end

  always_ff @(posedge clk) begin
    if (reset)
      flagsQ <= '0;
    else if (!StallE)
      flagsQ <= flagsNext;  // Held while Execute stalls
  end

  assign PreviousFlagsE = flagsQ;

endmodule

// File: rtl/writeGate.sv
`timescale 1ns/10ps

module writeGate (
  input  logic       clk,
  input  logic       reset,
  input  logic       StallM,
  input  logic       StallW,
  input  logic       FlushW,
  execCtrlIf.execute ctrl,
  input  logic       condEx,
  input  logic       doNotWriteReg,
  input  logic       pcSrcD,
  input  logic [1:0] ALUResultLowE,
  output logic       BranchTakenE,
  output logic       MemWriteM,
  output logic [3:0] ByteMaskM,
  output logic       MemtoRegW,
  output logic       RegWriteW,
  output logic       PCSrcW,
  output logic       PCWrPendingF
);

  logic       memWriteGatedE, regWriteGatedE, pcSrcGatedE;
  logic [3:0] byteMaskE;
  logic       memtoRegM, regWriteM, pcSrcM;

  // ============================
  // Execute gating
  // ============================
  assign BranchTakenE   = ctrl.branch & condEx;
  assign memWriteGatedE = ctrl.memWrite & condEx;
  assign regWriteGatedE = ctrl.regWrite & condEx & ~doNotWriteReg;
  assign pcSrcGatedE    = ctrl.pcSrc & condEx;

  // Byte lanes from the low address bits
  always_comb begin
    if (ctrl.halfword)
      byteMaskE = ALUResultLowE[1] ? 4'b1100 : 4'b0011;
    else if (ctrl.storeByte)
      byteMaskE = 4'b0001 << ALUResultLowE;  // Single lane
    else
      byteMaskE = 4'b1111;
  end

  // ============================
  // Memory and Writeback
  // ============================
  always_ff @(posedge clk) begin
    if (reset) begin
      MemWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
    end else if (!StallM) begin
      MemWriteM <= memWriteGatedE;
      memtoRegM <= ctrl.memtoReg;
      regWriteM <= regWriteGatedE;
      pcSrcM    <= pcSrcGatedE;
    end
  end

  always_ff @(posedge clk) begin
    if (!StallM)
      ByteMaskM <= byteMaskE;
  end

  always_ff @(posedge clk) begin
    if (reset || (FlushW && !StallW)) begin
      MemtoRegW <= 1'b0;
      RegWriteW <= 1'b0;
      PCSrcW    <= 1'b0;
    end else if (!StallW) begin
      MemtoRegW <= memtoRegM;
      RegWriteW <= regWriteM;
      PCSrcW    <= pcSrcM;
    end
  end

  // Any PC write still in flight blocks fetch
  assign PCWrPendingF = pcSrcD | ctrl.pcSrc | pcSrcM;

endmodule

// File: rtl/armController.sv
`timescale 1ns/10ps

module armController (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] InstrD,
  input  logic [3:0]  FlagsE,
  input  logic [1:0]  ALUResultLowE,  // Address bits from the datapath
  input  logic        StallE,
  input  logic        FlushE,
  input  logic        StallM,
  input  logic        StallW,
  input  logic        FlushW,
  output logic [1:0]  RegSrcD,
  output logic [1:0]  ImmSrcD,
  output logic [3:0]  ALUControlE,
  output logic        ALUSrcE,
  output logic [2:0]  ALUOperationE,
  output logic        InvertBE,
  output logic        ReverseInputsE,
  output logic        CVUpdateE,
  output logic        BranchTakenE,
  output logic [3:0]  PreviousFlagsE,
  output logic        MemWriteM,
  output logic [3:0]  ByteMaskM,
  output logic        MemtoRegW,
  output logic        RegWriteW,
  output logic        PCSrcW,
  output logic        PCWrPendingF
);

  logic pcSrcD, condEx, doNotWriteReg;

  execCtrlIf execCtrl ();

  // ============================
  // Decode
  // ============================
  instrDecoder decodeStage (
    .clk     (clk),
    .reset   (reset),
    .InstrD  (InstrD),
    .StallE  (StallE),
    .FlushE  (FlushE),
    .RegSrcD (RegSrcD),
    .ImmSrcD (ImmSrcD),
    .pcSrcD  (pcSrcD),
    .ctrl    (execCtrl.decode)
  );

  // ============================
  // Execute and beyond
  // ============================
  aluDecoder aluDec (
    .ctrl           (execCtrl.execute),
    .ALUOperationE  (ALUOperationE),
    .InvertBE       (InvertBE),
    .ReverseInputsE (ReverseInputsE),
    .CVUpdateE      (CVUpdateE),
    .doNotWriteReg  (doNotWriteReg)
  );

  condUnit condition (
    .clk            (clk),
    .reset          (reset),
    .StallE         (StallE),
    .FlagsE         (FlagsE),
    .ctrl           (execCtrl.execute),
    .condEx         (condEx),
    .PreviousFlagsE (PreviousFlagsE)
  );

  writeGate gate (
    .clk           (clk),
    .reset         (reset),
    .StallM        (StallM),
    .StallW        (StallW),
    .FlushW        (FlushW),
    .ctrl          (execCtrl.execute),
    .condEx        (condEx),
    .doNotWriteReg (doNotWriteReg),
    .pcSrcD        (pcSrcD),
    .ALUResultLowE (ALUResultLowE),
    .BranchTakenE  (BranchTakenE),
    .MemWriteM     (MemWriteM),
    .ByteMaskM     (ByteMaskM),
    .MemtoRegW     (MemtoRegW),
    .RegWriteW     (RegWriteW),
    .PCSrcW        (PCSrcW),
    .PCWrPendingF  (PCWrPendingF)
  );

  assign ALUControlE = execCtrl.aluControl;
  assign ALUSrcE     = execCtrl.aluSrc;

endmodule

// File: dv/armController_properties.sv
`timescale 1ns/10ps

module armControllerProperties (
  input logic        clk,
  input logic        reset,
  input logic [31:0] InstrD,
  input logic        StallE,
  input logic        FlushE,
  input logic        StallM,
  input logic        halfwordE,
  input logic        memtoRegE,
  input logic        MemWriteM,
  input logic        RegWriteW,
  input logic        PCSrcW,
  input logic        BranchTakenE,
  input logic        PCWrPendingF
);

  int failCount = 0;

  // Halfword load in Execute never turns into a store
  hwLoadNoWrite: assert property (@(posedge clk) disable iff (reset)
    halfwordE && memtoRegE && !StallM |=> !MemWriteM)
    else begin
      $error("Halfword load produced a memory write");
      failCount++;
    end

  // Decoded branch leaves a PC write pending in Execute
  branchPending: assert property (@(posedge clk) disable iff (reset)
    InstrD[27:26] == 2'b10 && !StallE && !FlushE |=> PCWrPendingF)
    else begin
      $error("Decoded branch left no pending PC write");
      failCount++;
    end

  resetQuiet: assert property (@(posedge clk)
    reset |=> !(MemWriteM || RegWriteW || PCSrcW || BranchTakenE))
    else begin
      $error("Write enable high after a reset edge");
      failCount++;
    end

endmodule

bind armController armControllerProperties props (
  .clk          (clk),
  .reset        (reset),
  .InstrD       (InstrD),
  .StallE       (StallE),
  .FlushE       (FlushE),
  .StallM       (StallM),
  .halfwordE    (execCtrl.halfword),
  .memtoRegE    (execCtrl.memtoReg),
  .MemWriteM    (MemWriteM),
  .RegWriteW    (RegWriteW),
  .PCSrcW       (PCSrcW),
  .BranchTakenE (BranchTakenE),
  .PCWrPendingF (PCWrPendingF)
);

// File: dv/ctrlChecker.sv
`timescale 1ns/10ps

module ctrlChecker import armCtrlPkg::*; (
  input logic        clk,
  input logic        enable,
  input logic [1:0]  testId,
  input logic [28:0] expected,
  input logic [28:0] actual     // DUT outputs, same layout as expected
);

  localparam int NumFields = 16;

  // Compared word, top field first
  string fieldName [NumFields] = '{"RegSrcD", "ImmSrcD", "ALUControlE", "ALUSrcE",
    "ALUOperationE", "InvertBE", "ReverseInputsE", "CVUpdateE", "BranchTakenE",
    "PreviousFlagsE", "MemWriteM", "ByteMaskM", "MemtoRegW", "RegWriteW", "PCSrcW",
    "PCWrPendingF"};
  int    fieldWidth [NumFields] = '{2, 2, 4, 1, 3, 1, 1, 1, 1, 4, 1, 4, 1, 1, 1, 1};
  string testName [4] = '{"steady", "stalls", "flushes", "mixed"};

  int testChecks  = 0;
  int testErrors  = 0;
  int totalTests  = 0;
  int failedTests = 0;
  int totalChecks = 0;
  int totalErrors = 0;

  // Mid-cycle, inputs were driven just after the rising edge
  always @(negedge clk) begin : compare
    int          pos;
    logic [28:0] expShift, actShift;
    logic [3:0]  fieldMask, expField, actField;
    if (enable) begin
      pos = 29;
      for (int i = 0; i < NumFields; i++) begin
        pos       = pos - fieldWidth[i];
        fieldMask = (4'd1 << fieldWidth[i]) - 4'd1;
        expShift  = expected >> pos;
        actShift  = actual >> pos;
        expField  = expShift[3:0] & fieldMask;
        actField  = actShift[3:0] & fieldMask;
        if (actField !== expField) begin
          testErrors++;
          $display("FAIL %s %s expected %0h actual %0h", testName[testId],
                   fieldName[i], expField, actField);
        end
      end
      testChecks++;
    end
  end

  task automatic finishTest();
    $display("Test %s: %0d cycles checked, %0d mismatches, %s", testName[testId],
             testChecks, testErrors, (testErrors == 0) ? "passed" : "failed");
    totalTests++;
    if (testErrors != 0)
      failedTests++;
    totalChecks += testChecks;
    totalErrors += testErrors;
    testChecks  = 0;
    testErrors  = 0;
  endtask

endmodule

// File: dv/armControllerTb.sv
`timescale 1ns/10ps

module armControllerTb import armCtrlPkg::*; ();

  localparam int CyclesPerTest = 200;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       aluOp;
    logic [3:0] aluControl;
    logic [1:0] flagWrite;
    logic       pcSrc;
    logic [3:0] cond;
    logic       halfword;
    logic       storeByte;
  } ctrlT;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] InstrD;
  logic [3:0]  FlagsE, ALUControlE, PreviousFlagsE, ByteMaskM;
  logic [1:0]  ALUResultLowE, RegSrcD, ImmSrcD;
  logic        StallE, FlushE, StallM, StallW, FlushW;
  logic        ALUSrcE, InvertBE, ReverseInputsE, CVUpdateE, BranchTakenE;
  logic [2:0]  ALUOperationE;
  logic        MemWriteM, MemtoRegW, RegWriteW, PCSrcW, PCWrPendingF;

  logic [28:0] expected;
  logic        checkEn, timedOut;
  logic [1:0]  testId;
  logic [31:0] rngState;
  int          cycleCount = 0;
  time         lastEdge;

  // Reference pipeline state
  ctrlT       refE;
  logic [3:0] refFlags, refMaskM;
  logic       refMemWriteM, refMemtoRegM, refRegWriteM, refPcSrcM;
  logic       refMemtoRegW, refRegWriteW, refPcSrcW;

  armController UUT (.*);

  ctrlChecker chk (
    .clk      (clk),
    .enable   (checkEn),
    .testId   (testId),
    .expected (expected),
    .actual   ({RegSrcD, ImmSrcD, ALUControlE, ALUSrcE, ALUOperationE, InvertBE,
                ReverseInputsE, CVUpdateE, BranchTakenE, PreviousFlagsE, MemWriteM,
                ByteMaskM, MemtoRegW, RegWriteW, PCSrcW, PCWrPendingF})
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    lastEdge = $time;
  end

  // ============================
  // Reference rules
  // ============================
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic ctrlT decodeClass(input logic [31:0] w);
    ctrlT c;
    logic isMem;
    c      = '0;
    isMem  = 1'b0;
    c.cond = w[31:28];
    case (w[27:26])
      2'b00: if (!w[25] && w[7] && w[4]) begin
        isMem      = 1'b1;  // Halfword transfer with bit 22 as the immediate form
        c.halfword = 1'b1;
        c.aluSrc   = w[22];
      end else begin
        c.aluSrc   = w[25];
        c.regWrite = 1'b1;
        c.aluOp    = 1'b1;
      end
      2'b01: begin
        isMem       = 1'b1;
        c.aluSrc    = ~w[25];
        c.storeByte = w[22] & ~w[20];
      end
      2'b10: begin
        c.regSrc = 2'b01;
        c.immSrc = 2'b10;
        c.aluSrc = 1'b1;
        c.branch = 1'b1;
      end
      default: ;
    endcase
    if (isMem) begin
      c.regSrc   = w[20] ? 2'b00 : 2'b10;  // Stores read Rd
      c.immSrc   = 2'b01;
      c.memtoReg = w[20];
      c.regWrite = w[20];
      c.memWrite = ~w[20];
    end
    if (c.aluOp)
      c.aluControl = w[24:21];
    else if (isMem)
      c.aluControl = w[23] ? OpAdd : OpSub;
    else
      c.aluControl = OpAdd;
    c.flagWrite = c.aluOp ? {2{w[20]}} : 2'b00;
    c.pcSrc     = (w[15:12] == 4'hf && c.regWrite) || c.branch;
    return c;
  endfunction

  // {operation, invertB, reverse, cvUpdate, noRegWrite}
  function automatic logic [6:0] aluRules(input ctrlT c);
    logic [2:0] op;
    logic       inv, rev, cv, noWrite;
    op      = AluAdd;
    inv     = 1'b0;
    rev     = 1'b0;
    cv      = 1'b0;
    noWrite = 1'b0;
    if (c.aluOp) begin
      case (c.aluControl)
        OpAnd, OpTst: op = AluAnd;
        OpEor, OpTeq: op = AluEor;
        OpOrr:        op = AluOrr;
        OpMov:        op = AluMov;
        OpBic:        op = AluBic;
        OpMvn:        op = AluMvn;
        default:      cv = 1'b1;  // Arithmetic
      endcase
      inv     = c.aluControl inside {OpSub, OpSbc, OpRsb, OpRsc, OpCmp};
      rev     = c.aluControl inside {OpRsb, OpRsc};
      noWrite = c.aluControl >= 4'd8 && c.aluControl <= 4'd11;
    end else begin
      inv = (c.aluControl == OpSub);
    end
    return {op, inv, rev, cv, noWrite};
  endfunction

  // Odd codes negate the even code below them
  function automatic logic condPasses(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v, base;
    {n, z, c, v} = f;
    case (cond[3:1])
      3'd0:    base = z;
      3'd1:    base = c;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = c & ~z;
      3'd5:    base = (n == v);
      3'd6:    base = ~z & (n == v);
      default: base = 1'b1;
    endcase
    if (cond == 4'hf)
      return 1'b0;
    if (cond == 4'he)
      return 1'b1;
    return base ^ cond[0];
  endfunction

  // ============================
  // Stimulus and model steps
  // ============================
  task automatic nextEdge();
    int startCount;
    int waited;
    startCount = cycleCount;
    waited     = 0;
    while (cycleCount == startCount && waited < 40) begin
      #1;
      waited++;
    end
    if (cycleCount == startCount) begin
      $display("Timed out waiting for a rising clock edge");
      timedOut = 1'b1;
    end else begin
      #(lastEdge + 1 - $time);  // Land 1 ns after the edge
    end
  endtask

  task automatic driveRandom();
    logic [31:0] r;
    rngState = xorshift(rngState);
    InstrD   = rngState;
    if (InstrD[27:26] == 2'b11)
      InstrD[27] = 1'b0;
    rngState      = xorshift(rngState);
    r             = rngState;
    FlagsE        = r[3:0];
    ALUResultLowE = r[5:4];
    StallE        = testId[0] && r[7:6] == 2'b00;
    StallM        = testId[0] && r[9:8] == 2'b00;
    StallW        = testId[0] && r[11:10] == 2'b00;
    FlushE        = testId[1] && r[13:12] == 2'b00;
    FlushW        = testId[1] && r[15:14] == 2'b00;
  endtask

  task automatic computeExpected();
    ctrlT       d;
    logic [6:0] alu;
    logic       ce;
    d   = decodeClass(InstrD);
    alu = aluRules(refE);
    ce  = condPasses(refE.cond, refFlags);
    expected = {d.regSrc, d.immSrc, refE.aluControl, refE.aluSrc, alu[6:1],
                refE.branch & ce, refFlags, refMemWriteM, refMaskM, refMemtoRegW,
                refRegWriteW, refPcSrcW, d.pcSrc | refE.pcSrc | refPcSrcM};
  endtask

  // Inputs still hold the values seen at the last edge
  task automatic advanceModel();
    logic [6:0] alu;
    logic       ce;
    logic [3:0] maskE;
    alu = aluRules(refE);
    ce  = condPasses(refE.cond, refFlags);
    if (refE.halfword) begin
      maskE = {{2{ALUResultLowE[1]}}, {2{~ALUResultLowE[1]}}};  // Upper or lower half
    end else if (refE.storeByte) begin
      maskE                = 4'b0000;
      maskE[ALUResultLowE] = 1'b1;
    end else begin
      maskE = 4'b1111;
    end

    if (reset || (FlushW && !StallW))
      {refMemtoRegW, refRegWriteW, refPcSrcW} = 3'b000;
    else if (!StallW)
      {refMemtoRegW, refRegWriteW, refPcSrcW} = {refMemtoRegM, refRegWriteM, refPcSrcM};

    if (!StallM)
      refMaskM = maskE;
    if (reset) begin
      {refMemWriteM, refMemtoRegM, refRegWriteM, refPcSrcM} = 4'b0000;
    end else if (!StallM) begin
      refMemWriteM = refE.memWrite & ce;
      refMemtoRegM = refE.memtoReg;
      refRegWriteM = refE.regWrite & ce & ~alu[0];
      refPcSrcM    = refE.pcSrc & ce;
    end

    if (reset) begin
      refFlags = 4'b0000;
    end else if (!StallE && ce) begin
      if (refE.flagWrite[1])
        refFlags[3:2] = FlagsE[3:2];
      if (refE.flagWrite[0])
        refFlags[1:0] = FlagsE[1:0];
    end

    if (reset)
      refE = '0;
    else if (!StallE)
      refE = FlushE ? '0 : decodeClass(InstrD);  // Flush leaves a bubble
  endtask

  initial begin
    rngState = 32'h3c38a8d2;
    timedOut = 1'b0;
    checkEn  = 1'b0;
    testId   = 2'd0;
    reset    = 1'b1;
    InstrD   = '0;
    FlagsE   = '0;
    ALUResultLowE = '0;
    {StallE, FlushE, StallM, StallW, FlushW} = 5'b00000;
    refE     = '0;
    refFlags = '0;
    refMaskM = 4'b1111;
    {refMemWriteM, refMemtoRegM, refRegWriteM, refPcSrcM} = 4'b0000;
    {refMemtoRegW, refRegWriteW, refPcSrcW} = 3'b000;
    expected = '0;

    repeat (2) begin
      nextEdge();
      advanceModel();
    end
    reset   = 1'b0;
    checkEn = 1'b1;

    // Tests differ only in how often stages stall or flush
    for (int t = 0; t < 4 && !timedOut; t++) begin
      testId = t[1:0];
      for (int i = 0; i < CyclesPerTest && !timedOut; i++) begin
        driveRandom();
        computeExpected();
        nextEdge();
        advanceModel();
      end
      chk.finishTest();
    end
    checkEn = 1'b0;

    $display("Tests: %0d run, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
             chk.totalTests, chk.failedTests, chk.totalChecks, chk.totalErrors,
             UUT.props.failCount);
    if (timedOut || chk.failedTests != 0 || UUT.props.failCount != 0)
      $display("Some tests failed");
    else
      $display("All tests passed");
    $finish;
  end

endmodule

// File: all.f
rtl/armCtrlPkg.sv
rtl/execCtrlIf.sv
rtl/instrDecoder.sv
rtl/aluDecoder.sv
rtl/condUnit.sv
rtl/writeGate.sv
rtl/armController.sv
dv/armController_properties.sv
dv/ctrlChecker.sv
dv/armControllerTb.sv
